//--- design/yupd_pkg.sv
// Y-matrix update unit shared definitions
// widths, memory line layout, change record, operand pair and FSM states
`default_nettype none

package yupd_pkg;

   localparam int unsigned tag_w        = 16;
   localparam int unsigned part_w       = 24;
   localparam int unsigned yval_w       = 2 * part_w;  // re then im
   localparam int unsigned node_w       = 9;           // node field of a diagonal tag
   localparam int unsigned line_entries = 8;

   typedef struct packed {
      logic [part_w-1:0] re;
      logic [part_w-1:0] im;
   } yval_t;

   typedef struct packed {
      logic [tag_w-1:0] tag;
      yval_t            val;
   } entry_t;

   // entry 0 is the leftmost entry of word 1, word 1 is the upper half
   typedef entry_t [0:line_entries-1] ymem_line_t;

   typedef struct packed {
      logic [tag_w-1:0] row;
      logic [tag_w-1:0] col;
      yval_t            delta;
   } change_t;

   typedef struct packed {
      yval_t val1;
      yval_t val2;
   } ex_ops_t;

   typedef struct packed {
      logic  diag_hit;
      yval_t diag_val;
      logic  offd_hit;
      yval_t offd_val;
      logic  spare;      // always zero
   } search_res_t;

   typedef enum logic [3:0] {
      idle, fetch_row, search_row, issue_diag_row, issue_offd_row,
      fetch_col, search_col, issue_diag_col, issue_offd_col, finish
   } seq_state_t;

endpackage

`default_nettype wire

//--- design/entry_search.sv
// Y-memory line search
// registers the diagonal entry for diag_key and the off-diagonal entry for
// search_key out of one eight-entry line, lowest slot wins
`timescale 1ns/1ps
`default_nettype none

module entry_search
   import yupd_pkg::*;
#(
   parameter int unsigned diag_marker_bits = 3
)
(
   input  logic             clock,
   input  logic             reset,
   input  logic             capture,
   input  logic [tag_w-1:0] search_key,
   input  logic [tag_w-1:0] diag_key,
   input  ymem_line_t       line,
   output search_res_t      result
);

   logic [line_entries-1:0] is_diag;    // slot carries the diagonal marker
   logic [line_entries-1:0] diag_match;
   logic [line_entries-1:0] offd_match;
   search_res_t             found;

   // per-slot tag decode
   always_comb
   begin
      for (int i = 0; i < line_entries; i++)
      begin
         is_diag[i]    = &line[i].tag[tag_w-1 -: diag_marker_bits];
         diag_match[i] = is_diag[i]
                         && (line[i].tag[node_w-1:0] == diag_key[node_w-1:0]);
         offd_match[i] = !is_diag[i] && (line[i].tag == search_key);
      end
   end

   // walk from the top slot down so the lowest match is written last
   always_comb
   begin
      found = '0;
      for (int i = line_entries - 1; i >= 0; i--)
      begin
         if (diag_match[i])
         begin
            found.diag_hit = 1'b1;
            found.diag_val = line[i].val;
         end
         if (offd_match[i])
         begin
            found.offd_hit = 1'b1;
            found.offd_val = line[i].val;
         end
      end
      found.spare = 1'b0;
   end

   always_ff @(posedge clock)
   begin
      if (!reset)
      begin
         result <= '0;
      end
      else if (capture)
      begin
         result <= found;   // one cycle after the line arrives
      end
   end

   // the sequencer captures a single line per fetch
   a_capture_single: assert property (
      @(posedge clock) disable iff (!reset)
      capture |=> !capture
   );

endmodule

`default_nettype wire

//--- design/update_sequencer.sv
// Y update sequencer
// fetches the row line then the column line and hands the four operand
// pairs to the execute unit and ends with a done or a miss pulse
`timescale 1ns/1ps
`default_nettype none

module update_sequencer
   import yupd_pkg::*;
(
   input  logic             clock,
   input  logic             reset,
   input  logic             start,
   input  change_t          change,
   input  logic             mem_ready_next,
   input  search_res_t      result,
   output logic             capture,
   output logic [tag_w-1:0] search_key,
   output logic [tag_w-1:0] diag_key,
   output logic             fetch_en,
   output logic [tag_w-1:0] fetch_row,
   output logic             ex_en,
   output ex_ops_t          ex_ops,
   input  logic             ex_done,
   output logic             done,
   output logic             miss
);

   seq_state_t state;
   seq_state_t state_next;
   change_t    change_q;     // record of the update in flight
   yval_t      row_offd;     // Yrc reused in the column pass
   logic       row_ok;
   logic       col_pass;

   assign row_ok   = result.diag_hit && result.offd_hit;
   assign col_pass = (state == fetch_col) || (state == search_col)
                     || (state == issue_diag_col) || (state == issue_offd_col);

   always_ff @(posedge clock)
   begin
      if (!reset)
      begin
         state <= idle;
      end
      else
      begin
         state <= state_next;
      end
   end

   // payload registers
   always_ff @(posedge clock)
   begin
      if ((state == idle) && start)
      begin
         change_q <= change;
      end
      if (state == issue_offd_row)
      begin
         row_offd <= result.offd_val;   // result is overwritten by the column line
      end
   end

   // next state
   always_comb
   begin
      state_next = state;
      case (state)
         idle:
         begin
            if (start)
            begin
               state_next = yupd_pkg::fetch_row;   // port owns the plain name
            end
         end
         yupd_pkg::fetch_row:
         begin
            if (mem_ready_next)
            begin
               state_next = search_row;
            end
         end
         search_row:
         begin
            state_next = issue_diag_row;
         end
         issue_diag_row:
         begin
            if (!row_ok)
            begin
               state_next = idle;   // miss with nothing issued
            end
            else if (ex_done)
            begin
               state_next = issue_offd_row;
            end
         end
         issue_offd_row:
         begin
            if (ex_done)
            begin
               state_next = fetch_col;
            end
         end
         fetch_col:
         begin
            if (mem_ready_next)
            begin
               state_next = search_col;
            end
         end
         search_col:
         begin
            state_next = issue_diag_col;
         end
         issue_diag_col:
         begin
            if (!result.diag_hit)
            begin
               state_next = idle;
            end
            else if (ex_done)
            begin
               state_next = issue_offd_col;
            end
         end
         issue_offd_col:
         begin
            if (ex_done)
            begin
               state_next = finish;
            end
         end
         finish:
         begin
            state_next = idle;
         end
         default:
         begin
            state_next = idle;
         end
      endcase
   end

   // output decode
   always_comb
   begin
      capture    = 1'b0;
      fetch_en   = 1'b0;
      fetch_row  = '1;               // no line requested
      ex_en      = 1'b0;
      ex_ops     = '0;
      done       = 1'b0;
      miss       = 1'b0;
      search_key = col_pass ? change_q.row : change_q.col;
      diag_key   = col_pass ? change_q.col : change_q.row;
      case (state)
         yupd_pkg::fetch_row:
         begin
            fetch_en  = 1'b1;
            fetch_row = change_q.row;
         end
         search_row:
         begin
            fetch_en  = 1'b1;         // held through the line cycle
            fetch_row = change_q.row;
            capture   = 1'b1;
         end
         issue_diag_row:
         begin
            ex_en       = row_ok;
            miss        = !row_ok;
            ex_ops.val1 = row_ok ? result.diag_val : '0;
            ex_ops.val2 = row_ok ? change_q.delta : '0;
         end
         issue_offd_row:
         begin
            ex_en       = 1'b1;
            ex_ops.val1 = result.offd_val;
         end
         fetch_col:
         begin
            fetch_en  = 1'b1;
            fetch_row = change_q.col;
         end
         search_col:
         begin
            fetch_en  = 1'b1;
            fetch_row = change_q.col;
            capture   = 1'b1;
         end
         issue_diag_col:
         begin
            ex_en       = result.diag_hit;
            miss        = !result.diag_hit;
            ex_ops.val1 = result.diag_hit ? result.diag_val : '0;
            ex_ops.val2 = result.diag_hit ? change_q.delta : '0;
         end
         issue_offd_col:
         begin
            ex_en       = 1'b1;
            ex_ops.val1 = row_offd;   // Ycr equals Yrc in a symmetric matrix
         end
         finish:
         begin
            done = 1'b1;
         end
         default:
         begin
         end
      endcase
   end

   a_fetch_ex_excl: assert property (
      @(posedge clock) disable iff (!reset)
      !(fetch_en && ex_en)
   );

   a_done_miss_excl: assert property (
      @(posedge clock) disable iff (!reset)
      !(done && miss)
   );

endmodule

`default_nettype wire

//--- design/y_update_top.sv
// Y-matrix update control path
// line search plus sequencer, drives the memory fetch and the execute unit
`timescale 1ns/1ps
`default_nettype none

module y_update_top
   import yupd_pkg::*;
#(
   parameter int unsigned diag_marker_bits = 3
)
(
   input  logic             clock,
   input  logic             reset,
   input  logic             start,
   input  change_t          change,
   input  logic             mem_ready_next,
   input  ymem_line_t       mem_line,
   input  logic             ex_done,
   output logic             fetch_en,
   output logic [tag_w-1:0] fetch_row,
   output logic             ex_en,
   output ex_ops_t          ex_ops,
   output logic             done,
   output logic             miss
);

   logic             capture;      // line valid this cycle
   logic [tag_w-1:0] search_key;
   logic [tag_w-1:0] diag_key;
   search_res_t      result;

   entry_search #(
      .diag_marker_bits (diag_marker_bits)
   ) search_i (
      .clock      (clock),
      .reset      (reset),
      .capture    (capture),
      .search_key (search_key),
      .diag_key   (diag_key),
      .line       (mem_line),
      .result     (result)
   );

   update_sequencer seq_i (
      .clock          (clock),
      .reset          (reset),
      .start          (start),
      .change         (change),
      .mem_ready_next (mem_ready_next),
      .result         (result),
      .capture        (capture),
      .search_key     (search_key),
      .diag_key       (diag_key),
      .fetch_en       (fetch_en),
      .fetch_row      (fetch_row),
      .ex_en          (ex_en),
      .ex_ops         (ex_ops),
      .ex_done        (ex_done),
      .done           (done),
      .miss           (miss)
   );

endmodule

`default_nettype wire

//--- tests/tb_checker.sv
// Y update unit checker
// follows ex_done, done and miss and compares them with the running table entry
`timescale 1ns/1ps
`default_nettype none

module tb_checker
   import yupd_pkg::*;
(
   input  logic             clock,
   input  logic             reset,
   input  logic             fetch_en,
   input  logic [tag_w-1:0] fetch_row,
   input  logic             mem_ready_next,
   input  logic             ex_en,
   input  ex_ops_t          ex_ops,
   input  logic             ex_done,
   input  logic             done,
   input  logic             miss,
   input  ex_ops_t [0:3]    exp_ops,
   input  logic             exp_done,
   input  logic [2:0]       exp_pairs,
   input  int               timeouts,
   input  logic             report,
   output int               error_count
);

   int      checks          = 0;
   int      value_errors    = 0;
   int      protocol_errors = 0;
   int      pair_idx        = 0;     // pairs consumed in this update
   int      reset_edges     = 0;
   logic    held_valid      = 1'b0;  // pair still waiting for ex_done
   ex_ops_t held_ops        = '0;
   logic    ready_d1        = 1'b0;
   logic    ready_d2        = 1'b0;
   logic    done_due        = 1'b0;

   assign error_count = value_errors + protocol_errors;

   task automatic compare(input string name, input logic [95:0] expected,
                          input logic [95:0] actual);
      checks++;
      if (actual !== expected)
      begin
         value_errors++;
         $display("Error at %0t: %s expected %0h got %0h", $time, name, expected, actual);
      end
   endtask

   task automatic flag_protocol(input string what);
      protocol_errors++;
      $display("Protocol error at %0t: %s", $time, what);
   endtask

   always @(posedge clock)
   begin
      if (!reset)
      begin
         reset_edges++;
         pair_idx   = 0;
         held_valid = 1'b0;
         done_due   = 1'b0;
         ready_d1   = 1'b0;
         ready_d2   = 1'b0;
         if (reset_edges > 1)   // state is known after the first reset edge
         begin
            compare("fetch_en", 0, fetch_en);
            compare("ex_en", 0, ex_en);
            compare("done", 0, done);
            compare("miss", 0, miss);
            compare("fetch_row", {tag_w{1'b1}}, fetch_row);
         end
      end
      else
      begin
         if (held_valid && !ex_en)
            flag_protocol("ex_en dropped before ex_done");
         else if (held_valid)
            compare("ex_ops while waiting", held_ops, ex_ops);
         if (ready_d2 && !ex_en && !miss)
            flag_protocol("neither ex_en nor miss one cycle after the line arrived");
         if (done_due && !done)
            flag_protocol("done did not follow the fourth ex_done");
         if (ex_done && pair_idx < 4)
            compare($sformatf("ex_ops pair %0d", pair_idx), exp_ops[pair_idx], ex_ops);
         else if (ex_done)
            flag_protocol("ex_done beyond the fourth pair");
         if (ex_done)
            pair_idx++;
         if (done || miss)
         begin
            compare("done", exp_done, done);
            compare("pair count", exp_pairs, pair_idx);
            pair_idx = 0;
         end
         done_due   = ex_done && (pair_idx == 4);
         held_valid = ex_en && !ex_done;
         held_ops   = ex_ops;
         ready_d2   = ready_d1;
         ready_d1   = mem_ready_next;
      end
   end

   always @(posedge report)
   begin
      $display("checker summary: %0d checks, %0d value errors, %0d protocol errors, %0d timeouts",
               checks, value_errors, protocol_errors, timeouts);
   end

endmodule

`default_nettype wire

//--- tests/tb_top.sv
// Y update unit testbench
// change records with their row and column lines plus memory and execute-unit models
`timescale 1ns/1ps
`default_nettype none

module tb_top
   import yupd_pkg::*;
();

   localparam int n_cases      = 10;
   localparam int case_timeout = 200;   // cycles per table entry

   typedef struct packed {
      change_t       chg;
      ymem_line_t    row_line;
      ymem_line_t    col_line;
      logic          exp_done;
      logic [2:0]    exp_pairs;
      ex_ops_t [0:3] ops;
      logic          stray_start;   // second start while busy
   } case_t;

   case_t            tbl [n_cases];
   case_t            cur            = '0;
   logic             clock          = 1'b0;
   logic             reset          = 1'b0;
   logic             start          = 1'b0;
   change_t          change         = '0;
   logic             mem_ready_next = 1'b0;
   ymem_line_t       mem_line       = '0;
   logic             ex_done        = 1'b0;
   logic             fetch_en;
   logic [tag_w-1:0] fetch_row;
   logic             ex_en;
   ex_ops_t          ex_ops;
   logic             done;
   logic             miss;
   logic             report         = 1'b0;
   int               timeouts       = 0;
   int               error_count;
   logic [31:0]      lfsr           = 32'h491d;
   logic             fetch_seen     = 1'b0;
   int               mem_count      = -1;
   int               ex_count       = -1;

   always #2 clock = ~clock;

   y_update_top #(.diag_marker_bits (3)) dut_i (.*);

   tb_checker checker_i (
      .exp_ops   (cur.ops),
      .exp_done  (cur.exp_done),
      .exp_pairs (cur.exp_pairs),
      .*
   );

   // galois lfsr stepped once per bit
   function automatic int unsigned draw_bits(input int unsigned n);
      int unsigned v;
      v = 0;
      for (int i = 0; i < n; i++)
      begin
         v    = (v << 1) | lfsr[0];
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      end
      return v;
   endfunction

   function automatic yval_t make_val(input int k, input int slot, input int salt);
      yval_t v;
      v.re = {8'(k + 1), 8'(salt), 8'(slot)};
      v.im = ~v.re;
      return v;
   endfunction

   function automatic logic [tag_w-1:0] diag_tag(input int node);
      return {3'b111, 4'b0000, 9'(node)};
   endfunction

   // rd ro cd give the slots of Yrr and Yrc in the row line and Ycc in the column line
   // a negative slot leaves that entry out
   task automatic add_case(input int k, input int row, input int col,
                           input int rd, input int ro, input int cd);
      tbl[k]           = '0;
      tbl[k].chg.row   = tag_w'(row);
      tbl[k].chg.col   = tag_w'(col);
      tbl[k].chg.delta = make_val(k, 0, 3);
      for (int i = 0; i < line_entries; i++)
      begin
         tbl[k].row_line[i] = {16'h7000 | tag_w'(k * 16 + i), make_val(k, i, 1)};
         tbl[k].col_line[i] = {16'h7800 | tag_w'(k * 16 + i), make_val(k, i, 2)};
      end
      if (rd >= 0)
         tbl[k].row_line[rd].tag = diag_tag(row);
      if (ro >= 0)
         tbl[k].row_line[ro].tag = tag_w'(col);
      if (cd >= 0)
         tbl[k].col_line[cd].tag = diag_tag(col);
      tbl[k].exp_done  = (rd >= 0) && (ro >= 0) && (cd >= 0);
      tbl[k].exp_pairs = (rd < 0 || ro < 0) ? 3'd0 : (cd < 0) ? 3'd2 : 3'd4;
      tbl[k].ops[0]    = {make_val(k, rd, 1), tbl[k].chg.delta};
      tbl[k].ops[1]    = {make_val(k, ro, 1), 48'd0};
      tbl[k].ops[2]    = {make_val(k, cd, 2), tbl[k].chg.delta};
      tbl[k].ops[3]    = tbl[k].ops[1];   // Ycr equals Yrc
   endtask

   task automatic build_table();
      add_case(0, 5, 9, 1, 4, 2);
      tbl[0].col_line[5].tag = 16'd5;       // Ycr in the column line is never used
      add_case(1, 12, 30, 0, 3, 7);
      tbl[1].row_line[6].tag = 16'd30;      // second match in a higher slot
      add_case(2, 7, 8, 2, -1, 0);
      tbl[2].row_line[5].tag = 16'd9;
      add_case(3, 100, 3, 7, 6, 0);
      tbl[3].stray_start = 1'b1;
      add_case(4, 20, 21, 3, 4, -1);
      tbl[4].col_line[1].tag = diag_tag(22);
      add_case(5, 300, 301, 7, 0, 3);
      add_case(6, 40, 41, -1, 1, 0);
      tbl[6].row_line[2].tag = diag_tag(39);
      add_case(7, 511, 2, 5, 6, 4);
      add_case(8, 64, 65, 2, 3, 6);
      tbl[8].row_line[5].tag = diag_tag(64);  // lower diagonal slot wins
      tbl[8].stray_start = 1'b1;
      add_case(9, 2, 511, 0, 1, 1);
   endtask

   task automatic run_case(input int k);
      int   cycles;
      logic ended;
      cycles = 0;
      ended  = 1'b0;
      @(posedge clock);
      start  <= 1'b1;
      change <= tbl[k].chg;
      cur    <= tbl[k];
      while (!ended && cycles < case_timeout)
      begin
         @(posedge clock);
         cycles++;
         start <= tbl[k].stray_start && (cycles == 4);   // lands mid update
         if (cycles == 4)
            change <= change_t'(~tbl[k].chg);
         ended = done || miss;
      end
      if (!ended)
      begin
         timeouts++;
         $display("Timeout: table entry %0d saw neither done nor miss in %0d cycles",
                  k, case_timeout);
      end
   endtask

   // memory answers a fetch after 0 to 3 cycles with the line at fetch_row
   always @(posedge clock)
   begin
      mem_ready_next <= 1'b0;
      ex_done        <= 1'b0;
      if (!reset)
      begin
         fetch_seen = 1'b0;
         mem_count  = -1;
         ex_count   = -1;
      end
      else
      begin
         if (mem_ready_next)
            mem_line <= (fetch_row == cur.chg.row) ? cur.row_line
                        : (fetch_row == cur.chg.col) ? cur.col_line : '0;
         if (!fetch_en)
            fetch_seen = 1'b0;
         else
         begin
            if (!fetch_seen)
               mem_count = draw_bits(2);
            fetch_seen = 1'b1;
            if (mem_count == 0)
               mem_ready_next <= 1'b1;
            mem_count = mem_count - 1;
         end
         // execute unit takes 1 to 4 cycles per pair
         if (!ex_en || ex_done)
            ex_count = -1;
         else
         begin
            if (ex_count < 0)
               ex_count = draw_bits(2);
            if (ex_count == 0)
               ex_done <= 1'b1;
            ex_count = ex_count - 1;
         end
      end
   end

   initial
   begin
      build_table();
      repeat (4) @(posedge clock);
      reset <= 1'b1;
      for (int k = 0; k < n_cases; k++)
      begin
         if (timeouts == 0)
            run_case(k);
      end
      repeat (2) @(posedge clock);
      report = 1'b1;   // checker prints its summary
      #1;
      if (error_count == 0 && timeouts == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- Bender.yml
package:
  name: y_update

sources:
  - design/yupd_pkg.sv
  - design/entry_search.sv
  - design/update_sequencer.sv
  - design/y_update_top.sv
  - target: test
    files:
      - tests/tb_checker.sv
      - tests/tb_top.sv

//--- vlog.f
design/yupd_pkg.sv
design/entry_search.sv
design/update_sequencer.sv
design/y_update_top.sv
tests/tb_checker.sv
tests/tb_top.sv
